/* Bender.yml */
package:
  name: mem_stage

export_include_dirs:
  - design

sources:
  - files:
      - design/rv_isa_pkg.sv
      - design/mem_pkg.sv
      - design/exe_mem_reg.sv
      - design/dmem_byte_bank.sv
      - design/load_align.sv
      - design/mem_stage_top.sv
  - target: test
    files:
      - verification/mem_stage_tb.sv

/* compile.f */
+incdir+design
design/rv_isa_pkg.sv
design/mem_pkg.sv
design/exe_mem_reg.sv
design/dmem_byte_bank.sv
design/load_align.sv
design/mem_stage_top.sv
verification/mem_stage_tb.sv

/* design/dmem_byte_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module dmem_byte_bank (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic [`DMEM_AW-1:0] addr,
    input  wire logic [7:0]          wdata,
    input  wire logic                write_n,
    input  wire logic                read,
    output logic [7:0]               rdata
);

    logic [7:0] mem [0:(1 << `DMEM_AW)-1];

    always_ff @(posedge clk) begin
        if (!write_n) begin
            mem[addr] <= wdata;
        end
    end

    // Read port only moves on a read, so the last load value stays put
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rdata <= 8'h00;
        end else if (read) begin
            rdata <= mem[addr];
        end
    end

    // The EX/MEM register never issues a read and a write together
    no_read_write_overlap: assert property (
        @(posedge clk) disable iff (!reset)
        !(read && !write_n)
    );

endmodule

`default_nettype wire

/* design/exe_mem_reg.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module exe_mem_reg (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic [`XLEN-1:0]    exe_alu_out,
    input  wire logic [`XLEN-1:0]    exe_store_data,
    input  wire logic [2:0]          exe_funct3,
    input  wire logic [`XLEN-1:0]    exe_pc,
    input  wire logic [4:0]          exe_write_addr,
    input  wire logic                exe_rd_src,
    input  wire logic                exe_mem_to_reg,
    input  wire logic                exe_mem_write,
    input  wire logic                exe_mem_read,
    input  wire logic                exe_reg_write,
    input  wire logic                exe_f_reg_write,
    input  wire logic                im_stall,
    input  wire logic                dm_stall,
    output mem_pkg::mem_word_u       mem_wdata,
    output mem_pkg::lane_mask_t      mem_write_mask,
    output logic [`XLEN-1:0]         mem_addr,
    output logic                     mem_read,
    output logic [2:0]               mem_funct3,
    output logic [`XLEN-1:0]         mem_pc,
    output logic [4:0]               mem_write_addr,
    output logic                     mem_rd_src,
    output logic                     mem_mem_to_reg,
    output logic                     mem_reg_write,
    output logic                     mem_f_reg_write
);

    mem_pkg::mem_word_u  store_in;
    mem_pkg::mem_word_u  store_lanes;
    mem_pkg::lane_mask_t store_mask;

    assign store_in.word = exe_store_data;

    // Store lane steering
    // Narrow data is copied into every lane, the mask picks the live ones
    always_comb begin
        store_lanes.word = store_in.word;
        store_mask = '1;
        if (exe_mem_write) begin
            case (rv_isa_pkg::lsu_funct3_e'(exe_funct3))
                rv_isa_pkg::LSU_B: begin
                    store_lanes.bytes = {`DMEM_LANES{store_in.bytes[0]}};
                    store_mask = ~(mem_pkg::lane_mask_t'(1) << exe_alu_out[1:0]);
                end
                rv_isa_pkg::LSU_H: begin
                    store_lanes.halves = {2{store_in.halves[0]}};
                    // Address bit 1 picks the upper pair
                    store_mask = exe_alu_out[1] ? 4'b0011 : 4'b1100;
                end
                default: begin
                    store_mask = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mem_addr        <= '0;
            mem_wdata       <= '0;
            mem_write_mask  <= '1;
            mem_read        <= 1'b0;
            mem_funct3      <= 3'd0;
            mem_pc          <= '0;
            mem_write_addr  <= 5'd0;
            mem_rd_src      <= 1'b0;
            mem_mem_to_reg  <= 1'b0;
            mem_reg_write   <= 1'b0;
            mem_f_reg_write <= 1'b0;
        end else if (im_stall && !dm_stall) begin
            // Keep the record but drop the access so it happens only once
            mem_read       <= 1'b0;
            mem_write_mask <= '1;
        end else if (!dm_stall) begin
            mem_addr        <= exe_alu_out;
            mem_wdata       <= store_lanes;
            mem_write_mask  <= store_mask;
            mem_read        <= exe_mem_read;
            mem_funct3      <= exe_funct3;
            mem_pc          <= exe_pc;
            mem_write_addr  <= exe_write_addr;
            mem_rd_src      <= exe_rd_src;
            mem_mem_to_reg  <= exe_mem_to_reg;
            mem_reg_write   <= exe_reg_write;
            mem_f_reg_write <= exe_f_reg_write;
        end
        // dm_stall holds everything, the access simply repeats
    end

    // A load never carries a write into the banks
    read_without_write: assert property (
        @(posedge clk) disable iff (!reset)
        mem_read |-> (&mem_write_mask)
    );

endmodule

`default_nettype wire

/* design/load_align.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module load_align (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire mem_pkg::mem_word_u rdata,
    input  wire logic [`XLEN-1:0]   mem_alu_out,
    input  wire logic [2:0]         mem_funct3,
    input  wire logic [`XLEN-1:0]   mem_pc,
    input  wire logic [4:0]         mem_write_addr,
    input  wire logic               mem_rd_src,
    input  wire logic               mem_mem_to_reg,
    input  wire logic               mem_reg_write,
    input  wire logic               mem_f_reg_write,
    input  wire logic               im_stall,
    input  wire logic               dm_stall,
    output logic                    wb_reg_write,
    output logic                    wb_f_reg_write,
    output logic [4:0]              wb_write_addr,
    output logic [`XLEN-1:0]        wb_data
);

    logic [`XLEN-1:0] alu_q;
    logic [`XLEN-1:0] pc_q;
    logic [2:0]       funct3_q;
    logic             rd_src_q;
    logic             mem_to_reg_q;
    logic [7:0]       load_byte;
    logic [15:0]      load_half;
    logic [`XLEN-1:0] load_val;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            alu_q          <= '0;
            pc_q           <= '0;
            funct3_q       <= 3'd0;
            rd_src_q       <= 1'b0;
            mem_to_reg_q   <= 1'b0;
            wb_write_addr  <= 5'd0;
            wb_reg_write   <= 1'b0;
            wb_f_reg_write <= 1'b0;
        end else if (!im_stall && !dm_stall) begin
            alu_q          <= mem_alu_out;
            pc_q           <= mem_pc;
            funct3_q       <= mem_funct3;
            rd_src_q       <= mem_rd_src;
            mem_to_reg_q   <= mem_mem_to_reg;
            wb_write_addr  <= mem_write_addr;
            wb_reg_write   <= mem_reg_write;
            wb_f_reg_write <= mem_f_reg_write;
        end
    end

    // Byte offset of the load picks the lane
    assign load_byte = rdata.bytes[alu_q[1:0]];
    assign load_half = rdata.halves[alu_q[1]];

    always_comb begin
        case (rv_isa_pkg::lsu_funct3_e'(funct3_q))
            rv_isa_pkg::LSU_B:  load_val = {{(`XLEN-8){load_byte[7]}}, load_byte};
            rv_isa_pkg::LSU_BU: load_val = {{(`XLEN-8){1'b0}}, load_byte};
            rv_isa_pkg::LSU_H:  load_val = {{(`XLEN-16){load_half[15]}}, load_half};
            rv_isa_pkg::LSU_HU: load_val = {{(`XLEN-16){1'b0}}, load_half};
            default:            load_val = rdata.word;
        endcase
    end

    // Load value first, then link address, then ALU result
    assign wb_data = mem_to_reg_q ? load_val :
                     rd_src_q     ? pc_q + `XLEN'd4 :
                                    alu_q;

endmodule

`default_nettype wire

/* design/mem_pkg.sv */
`default_nettype none

`include "rv_macros.svh"

package mem_pkg;

    // One data memory word seen as a whole, as bytes or as halfwords
    typedef union packed {
        logic [`XLEN-1:0]            word;
        logic [`DMEM_LANES-1:0][7:0] bytes;
        logic [1:0][15:0]            halves;
    } mem_word_u;

    // Per-lane write enable, active low
    // All ones means no lane is written
    typedef logic [`DMEM_LANES-1:0] lane_mask_t;

endpackage

`default_nettype wire

/* design/mem_stage_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module mem_stage_top (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic [`XLEN-1:0] exe_alu_out,
    input  wire logic [`XLEN-1:0] exe_store_data,
    input  wire logic [2:0]       exe_funct3,
    input  wire logic [`XLEN-1:0] exe_pc,
    input  wire logic [4:0]       exe_write_addr,
    input  wire logic             exe_rd_src,
    input  wire logic             exe_mem_to_reg,
    input  wire logic             exe_mem_write,
    input  wire logic             exe_mem_read,
    input  wire logic             exe_reg_write,
    input  wire logic             exe_f_reg_write,
    input  wire logic             im_stall,
    input  wire logic             dm_stall,
    output logic                  wb_reg_write,
    output logic                  wb_f_reg_write,
    output logic [4:0]            wb_write_addr,
    output logic [`XLEN-1:0]      wb_data
);

    mem_pkg::mem_word_u          mem_wdata;
    mem_pkg::lane_mask_t         mem_write_mask;
    mem_pkg::mem_word_u          rd_word;
    logic [`DMEM_LANES-1:0][7:0] bank_rdata;
    logic [`XLEN-1:0]            mem_addr;
    logic                        mem_read;
    logic [2:0]                  mem_funct3;
    logic [`XLEN-1:0]            mem_pc;
    logic [4:0]                  mem_write_addr;
    logic                        mem_rd_src;
    logic                        mem_mem_to_reg;
    logic                        mem_reg_write;
    logic                        mem_f_reg_write;

    exe_mem_reg u_exe_mem_reg (
        .clk             (clk),
        .reset           (reset),
        .exe_alu_out     (exe_alu_out),
        .exe_store_data  (exe_store_data),
        .exe_funct3      (exe_funct3),
        .exe_pc          (exe_pc),
        .exe_write_addr  (exe_write_addr),
        .exe_rd_src      (exe_rd_src),
        .exe_mem_to_reg  (exe_mem_to_reg),
        .exe_mem_write   (exe_mem_write),
        .exe_mem_read    (exe_mem_read),
        .exe_reg_write   (exe_reg_write),
        .exe_f_reg_write (exe_f_reg_write),
        .im_stall        (im_stall),
        .dm_stall        (dm_stall),
        .mem_wdata       (mem_wdata),
        .mem_write_mask  (mem_write_mask),
        .mem_addr        (mem_addr),
        .mem_read        (mem_read),
        .mem_funct3      (mem_funct3),
        .mem_pc          (mem_pc),
        .mem_write_addr  (mem_write_addr),
        .mem_rd_src      (mem_rd_src),
        .mem_mem_to_reg  (mem_mem_to_reg),
        .mem_reg_write   (mem_reg_write),
        .mem_f_reg_write (mem_f_reg_write)
    );

    // One bank per byte lane, all sharing the word address
    for (genvar lane = 0; lane < `DMEM_LANES; lane++) begin : g_bank
        dmem_byte_bank u_bank (
            .clk     (clk),
            .reset   (reset),
            .addr    (mem_addr[`DMEM_AW+1:2]),
            .wdata   (mem_wdata.bytes[lane]),
            .write_n (mem_write_mask[lane]),
            .read    (mem_read),
            .rdata   (bank_rdata[lane])
        );
    end

    assign rd_word.bytes = bank_rdata;

    load_align u_load_align (
        .clk             (clk),
        .reset           (reset),
        .rdata           (rd_word),
        .mem_alu_out     (mem_addr),
        .mem_funct3      (mem_funct3),
        .mem_pc          (mem_pc),
        .mem_write_addr  (mem_write_addr),
        .mem_rd_src      (mem_rd_src),
        .mem_mem_to_reg  (mem_mem_to_reg),
        .mem_reg_write   (mem_reg_write),
        .mem_f_reg_write (mem_f_reg_write),
        .im_stall        (im_stall),
        .dm_stall        (dm_stall),
        .wb_reg_write    (wb_reg_write),
        .wb_f_reg_write  (wb_f_reg_write),
        .wb_write_addr   (wb_write_addr),
        .wb_data         (wb_data)
    );

endmodule

`default_nettype wire

/* design/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // funct3 field of loads and stores
    // Unsigned encodings only occur on loads
    typedef enum logic [2:0] {
        LSU_B  = 3'b000,
        LSU_H  = 3'b001,
        LSU_W  = 3'b010,
        LSU_BU = 3'b100,
        LSU_HU = 3'b101
    } lsu_funct3_e;

endpackage

`default_nettype wire

/* design/rv_macros.svh */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Integer register and data word width
`define XLEN 32

// Byte lanes per data memory word
`define DMEM_LANES 4

// Word address width of one bank, 256 words deep
`define DMEM_AW 8

`endif

/* verification/mem_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module mem_stage_tb;

    // Upper bound on issued operations for the watchdog
    localparam int TOTAL_OPS = 64;
    // Control bits {rd_src, mem_to_reg, mem_write, mem_read, reg_write, f_reg_write}
    localparam logic [5:0] CTL_NOP    = 6'b000000;
    localparam logic [5:0] CTL_STORE  = 6'b001000;
    localparam logic [5:0] CTL_LOAD   = 6'b010110;
    localparam logic [5:0] CTL_FLOAD  = 6'b010101;
    localparam logic [5:0] CTL_ALU    = 6'b000010;
    localparam logic [5:0] CTL_JUMP   = 6'b100010;
    localparam logic [5:0] CTL_WRITES = 6'b000011;

    logic             clk = 1'b0;
    logic             reset;
    logic [`XLEN-1:0] exe_alu_out;
    logic [`XLEN-1:0] exe_store_data;
    logic [`XLEN-1:0] exe_pc;
    logic [2:0]       exe_funct3;
    logic [4:0]       exe_write_addr;
    logic             exe_rd_src;
    logic             exe_mem_to_reg;
    logic             exe_mem_write;
    logic             exe_mem_read;
    logic             exe_reg_write;
    logic             exe_f_reg_write;
    logic             im_stall;
    logic             dm_stall;
    logic             wb_reg_write;
    logic             wb_f_reg_write;
    logic [4:0]       wb_write_addr;
    logic [`XLEN-1:0] wb_data;
    logic [`XLEN-1:0] ref_mem [0:(1 << `DMEM_AW)-1];
    logic [31:0]      rng_state;
    int               errors;

    mem_stage_top u_dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Expected load result from the RV32 extension rules
    function automatic logic [`XLEN-1:0] model_load(input logic [`XLEN-1:0] addr,
                                                    input logic [2:0] f3);
        logic [`XLEN-1:0] w;
        logic [7:0]       b;
        logic [15:0]      h;
        w = ref_mem[addr[`DMEM_AW+1:2]];
        b = w[8*addr[1:0] +: 8];
        h = w[16*addr[1] +: 16];
        case (f3)
            3'b000:  return {{24{b[7]}}, b};
            3'b100:  return {24'h0, b};
            3'b001:  return {{16{h[15]}}, h};
            3'b101:  return {16'h0, h};
            default: return w;
        endcase
    endfunction

    task automatic model_store(input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] data,
                               input logic [2:0] f3);
        case (f3)
            3'b000:  ref_mem[addr[`DMEM_AW+1:2]][8*addr[1:0] +: 8] = data[7:0];
            3'b001:  ref_mem[addr[`DMEM_AW+1:2]][16*addr[1] +: 16] = data[15:0];
            default: ref_mem[addr[`DMEM_AW+1:2]] = data;
        endcase
    endtask

    task automatic check_data(input string name, input logic [`XLEN-1:0] exp,
                              input logic [`XLEN-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic issue(input logic [`XLEN-1:0] alu, input logic [`XLEN-1:0] sdata,
                         input logic [2:0] f3, input logic [`XLEN-1:0] pc,
                         input logic [4:0] waddr, input logic [5:0] ctrl);
        exe_alu_out = alu;
        exe_store_data = sdata;
        exe_funct3 = f3;
        exe_pc = pc;
        exe_write_addr = waddr;
        {exe_rd_src, exe_mem_to_reg, exe_mem_write, exe_mem_read,
         exe_reg_write, exe_f_reg_write} = ctrl;
    endtask

    task automatic step();
        @(posedge clk);
        @(negedge clk);
    endtask

    // Bubble after every operation covers the two cycle latency
    task automatic retire();
        step();
        issue('0, '0, '0, '0, '0, CTL_NOP);
        step();
    endtask

    task automatic do_store(input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] data,
                            input logic [2:0] f3);
        issue(addr, data, f3, '0, '0, CTL_STORE);
        model_store(addr, data, f3);
        retire();
    endtask

    task automatic load_check(input logic [`XLEN-1:0] addr, input logic [2:0] f3,
                              input logic [4:0] waddr, input logic [5:0] ctrl);
        issue(addr, '0, f3, '0, waddr, ctrl);
        retire();
        check_data("wb_data", model_load(addr, f3), wb_data);
        check_addr("wb_write_addr", waddr, wb_write_addr);
        check_flag("wb_reg_write", ctrl[1], wb_reg_write);
        check_flag("wb_f_reg_write", ctrl[0], wb_f_reg_write);
    endtask

    task automatic reset_test();
        // Both write enables wait at the inputs while reset holds the stages
        issue('0, '0, '0, '0, 5'd1, CTL_WRITES);
        repeat (10) begin
            @(negedge clk);
            check_flag("wb_reg_write", 1'b0, wb_reg_write);
            check_flag("wb_f_reg_write", 1'b0, wb_f_reg_write);
        end
        reset = 1'b1;
        step();
        check_flag("wb_reg_write", 1'b0, wb_reg_write);
        check_flag("wb_f_reg_write", 1'b0, wb_f_reg_write);
    endtask

    task automatic word_roundtrip_test();
        logic [`XLEN-1:0] addrs [8];
        for (int i = 0; i < 8; i++) begin
            addrs[i] = next_random() & 32'h0000_03fc;
            do_store(addrs[i], next_random(), rv_isa_pkg::LSU_W);
        end
        for (int i = 0; i < 8; i++) begin
            load_check(addrs[i], rv_isa_pkg::LSU_W, 5'(i + 1), CTL_LOAD);
        end
    endtask

    task automatic narrow_store_test();
        do_store(32'h100, next_random(), rv_isa_pkg::LSU_W);
        for (int off = 0; off < 4; off++) begin
            do_store(32'h100 + 32'(off), next_random(), rv_isa_pkg::LSU_B);
            load_check(32'h100, rv_isa_pkg::LSU_W, 5'd3, CTL_LOAD);
        end
        for (int half = 0; half < 2; half++) begin
            do_store(32'h100 + 32'(2 * half), next_random(), rv_isa_pkg::LSU_H);
            load_check(32'h100, rv_isa_pkg::LSU_W, 5'd4, CTL_LOAD);
        end
    endtask

    task automatic load_ext_test();
        // Bytes and halves with the top bit clear and set
        do_store(32'h200, 32'h80ff_7f01, rv_isa_pkg::LSU_W);
        for (int off = 0; off < 4; off++) begin
            load_check(32'h200 + 32'(off), rv_isa_pkg::LSU_B, 5'(off + 8), CTL_LOAD);
            load_check(32'h200 + 32'(off), rv_isa_pkg::LSU_BU, 5'(off + 16), CTL_FLOAD);
        end
        for (int half = 0; half < 2; half++) begin
            load_check(32'h200 + 32'(2 * half), rv_isa_pkg::LSU_H, 5'd20, CTL_FLOAD);
            load_check(32'h200 + 32'(2 * half), rv_isa_pkg::LSU_HU, 5'd31, CTL_LOAD);
        end
    endtask

    task automatic non_load_test();
        logic [`XLEN-1:0] alu;
        logic [`XLEN-1:0] pc;
        do_store(32'h300, next_random(), rv_isa_pkg::LSU_W);
        for (int i = 0; i < 4; i++) begin
            // Result doubles as an address of live data, which must stay untouched
            alu = (next_random() & ~32'h3ff) | 32'h300;
            pc = next_random();
            issue(alu, next_random(), '0, pc, 5'(i + 1), (i % 2 == 1) ? CTL_JUMP : CTL_ALU);
            retire();
            check_data("wb_data", (i % 2 == 1) ? pc + 32'd4 : alu, wb_data);
            check_flag("wb_reg_write", 1'b1, wb_reg_write);
        end
        load_check(32'h300, rv_isa_pkg::LSU_W, 5'd9, CTL_LOAD);
    endtask

    task automatic stalled_access(input logic use_dm, input logic is_load,
                                  input logic [`XLEN-1:0] addr);
        logic [`XLEN-1:0] marker;
        logic [`XLEN-1:0] data;
        marker = next_random();
        data = next_random();
        // ALU op ahead of the access holds the WB outputs during the stall
        issue(marker, '0, '0, '0, 5'd5, CTL_ALU);
        step();
        if (is_load) begin
            issue(addr, '0, rv_isa_pkg::LSU_W, '0, 5'd6, CTL_LOAD);
        end else begin
            issue(addr, data, rv_isa_pkg::LSU_W, '0, 5'd0, CTL_STORE);
            model_store(addr, data, rv_isa_pkg::LSU_W);
        end
        step();
        issue('0, '0, '0, '0, '0, CTL_NOP);
        im_stall = !use_dm;
        dm_stall = use_dm;
        repeat (4) begin
            step();
            check_data("wb_data", marker, wb_data);
            check_addr("wb_write_addr", 5'd5, wb_write_addr);
            check_flag("wb_reg_write", 1'b1, wb_reg_write);
        end
        im_stall = 1'b0;
        dm_stall = 1'b0;
        step();
        check_flag("wb_reg_write", is_load, wb_reg_write);
        if (is_load) begin
            check_data("wb_data", model_load(addr, rv_isa_pkg::LSU_W), wb_data);
        end else begin
            load_check(addr, rv_isa_pkg::LSU_W, 5'd7, CTL_LOAD);
        end
    endtask

    task automatic stall_test();
        stalled_access(1'b0, 1'b0, 32'h380);
        stalled_access(1'b1, 1'b1, 32'h380);
        stalled_access(1'b1, 1'b0, 32'h384);
        stalled_access(1'b0, 1'b1, 32'h384);
    endtask

    initial begin
        rng_state = 32'hd6da42d9;
        errors = 0;
        reset = 1'b0;
        im_stall = 1'b0;
        dm_stall = 1'b0;
        issue('0, '0, '0, '0, '0, CTL_NOP);
        reset_test();
        word_roundtrip_test();
        narrow_store_test();
        load_ext_test();
        non_load_test();
        stall_test();
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (TOTAL_OPS * 20 + 1000) @(posedge clk);
        $display("Watchdog expired, tests did not finish, %0d errors so far", errors);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
